// File: common/pkt_check_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizing macros for the stream packet checker.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PKT_CHECK_DEFINES_SVH
`define PKT_CHECK_DEFINES_SVH

// Number of stream ports.
`define PKT_NUM_PORTS 2

// Bytes carried by one beat.
`define PKT_DATA_BYTES 4

// Largest packet in bytes.
`define PKT_MTU_BYTES 64

// Expected packets held per port.
`define PKT_NUM_PKTS 4

// Number of destination ids.
`define PKT_NUM_DESTS 4

`endif

// File: common/pkt_check_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the stream packet checker.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pkt_check_defines.svh"

package pkt_check_pkg;

    // One beat of stream data.
    typedef logic [`PKT_DATA_BYTES*8-1:0] beat_t;

    // Byte enables of a beat.
    typedef logic [`PKT_DATA_BYTES-1:0] keep_t;

    typedef logic [$clog2(`PKT_NUM_DESTS)-1:0] dest_t;          // Destination id.

    // Byte length, wide enough to hold a full MTU.
    typedef logic [$clog2(`PKT_MTU_BYTES+1)-1:0] blen_t;

    typedef logic [$clog2(`PKT_MTU_BYTES/`PKT_DATA_BYTES)-1:0] beat_idx_t;  // Beat in packet.

    typedef logic [$clog2(`PKT_NUM_PKTS)-1:0] pkt_idx_t;        // Packet in store.

    typedef logic [7:0] cnt_t;                                  // Packet and error counts.

    typedef logic [$clog2(`PKT_NUM_PORTS)-1:0] port_idx_t;      // Port select on load bus.

    // What a packet must look like apart from its data.
    typedef struct packed {
        blen_t blen;                                            // Expected byte length.
        dest_t dest;                                            // Expected tdest.
    } pkt_desc_t;

    typedef logic [3:0] stall_t;                                // Longest ready stall.

endpackage

// File: packet_checker/expected_pkt_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expected packet store, one write port and a combinational read port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module expected_pkt_store #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 4
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  entry_t                   wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output entry_t                   rdata
);

    // Loaded by the host before traffic starts.
    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;                 // Visible to the reader next cycle.
        end
    end

    assign rdata = mem[raddr];                   // Same-cycle lookup for the checker.

endmodule

// File: packet_checker/packet_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-port packet checker against loaded expected beats and descriptors.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pkt_check_defines.svh"
`timescale 1ns/1ps

module packet_checker (
    input  logic                     clk,
    input  logic                     rst_n,
    // Stream in.
    input  pkt_check_pkg::beat_t     tdata,
    input  pkt_check_pkg::keep_t     tkeep,
    input  logic                     tvalid,
    input  logic                     tlast,
    input  pkt_check_pkg::dest_t     tdest,
    input  logic                     tready_in,
    output logic                     beat_fire,
    // Expectation load.
    input  logic                     data_we,
    input  logic                     desc_we,
    input  pkt_check_pkg::pkt_idx_t  load_pkt,
    input  pkt_check_pkg::beat_idx_t load_beat,
    input  pkt_check_pkg::beat_t     load_data,
    input  pkt_check_pkg::pkt_desc_t load_desc,
    // Status.
    input  pkt_check_pkg::cnt_t      num_tx_pkts,
    output logic                     pkt_done,
    output logic                     pkt_ok,
    output logic                     all_done,
    output pkt_check_pkg::cnt_t      pkt_count,
    output pkt_check_pkg::cnt_t      err_count
);

    import pkt_check_pkg::*;

    localparam int BEATS_PER_PKT = `PKT_MTU_BYTES / `PKT_DATA_BYTES;
    localparam int DATA_DEPTH    = `PKT_NUM_PKTS * BEATS_PER_PKT;
    localparam int KEEP_CNT_W    = $clog2(`PKT_DATA_BYTES + 1);

    pkt_idx_t              pkt_idx;              // Packet now arriving.
    beat_idx_t             beat_idx;             // Beat within that packet.
    blen_t                 len_acc;              // Bytes of earlier beats.
    logic                  data_err;
    logic                  over_err;
    beat_t                 exp_beat;
    pkt_desc_t             exp_desc;
    keep_t                 byte_mis;
    logic [KEEP_CNT_W-1:0] keep_bytes;
    blen_t                 final_len;
    logic                  beyond_now;
    logic                  pkt_bad;

    expected_pkt_store #(
        .entry_t ( beat_t     ),
        .DEPTH   ( DATA_DEPTH )
    ) u_beat_store (
        .clk   ( clk                  ),
        .we    ( data_we              ),
        .waddr ( {load_pkt, load_beat} ),
        .wdata ( load_data            ),
        .raddr ( {pkt_idx, beat_idx}  ),
        .rdata ( exp_beat             )
    );

    expected_pkt_store #(
        .entry_t ( pkt_desc_t    ),
        .DEPTH   ( `PKT_NUM_PKTS )
    ) u_desc_store (
        .clk   ( clk       ),
        .we    ( desc_we   ),
        .waddr ( load_pkt  ),
        .wdata ( load_desc ),
        .raddr ( pkt_idx   ),
        .rdata ( exp_desc  )
    );

    assign beat_fire = tvalid & tready_in;

    // Compare only the bytes under tkeep and count them.
    always_comb begin
        byte_mis   = '0;
        keep_bytes = '0;
        for (int b = 0; b < `PKT_DATA_BYTES; b++) begin
            if (tkeep[b]) begin
                keep_bytes  = keep_bytes + 1'b1;
                byte_mis[b] = (tdata[8*b +: 8] != exp_beat[8*b +: 8]);
            end
        end
    end

    assign final_len  = len_acc + blen_t'(keep_bytes);
    assign beyond_now = (len_acc >= exp_desc.blen);     // Beat past expected end.

    assign pkt_bad = data_err | over_err | (|byte_mis) | beyond_now |
                     (final_len != exp_desc.blen) | (tdest != exp_desc.dest);

    // Position and sticky errors within the packet.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_idx  <= '0;
            beat_idx <= '0;
            len_acc  <= '0;
            data_err <= 1'b0;
            over_err <= 1'b0;
        end else if (beat_fire) begin
            if (tlast) begin
                pkt_idx  <= pkt_idx + 1'b1;     // Next expected packet.
                beat_idx <= '0;
                len_acc  <= '0;
                data_err <= 1'b0;
                over_err <= 1'b0;
            end else begin
                beat_idx <= beat_idx + 1'b1;
                len_acc  <= len_acc + blen_t'(`PKT_DATA_BYTES);
                data_err <= data_err | (|byte_mis);
                over_err <= over_err | beyond_now;
            end
        end
    end

    // Result of each packet, one cycle after its last beat.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_done  <= 1'b0;
            pkt_ok    <= 1'b0;
            pkt_count <= '0;
            err_count <= '0;
        end else begin
            pkt_done <= beat_fire & tlast;
            if (beat_fire && tlast) begin
                pkt_ok    <= !pkt_bad;
                pkt_count <= pkt_count + 1'b1;
                if (pkt_bad) begin
                    err_count <= err_count + 1'b1;
                end
            end
        end
    end

    assign all_done = (num_tx_pkts != '0) && (pkt_count >= num_tx_pkts);

endmodule

// File: packet_checker/packet_checker_array.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One packet checker per port and the load bus decode.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pkt_check_defines.svh"
`timescale 1ns/1ps

module packet_checker_array (
    input  logic                      clk,
    input  logic                      rst_n,
    input  pkt_check_pkg::beat_t      s_tdata     [`PKT_NUM_PORTS-1:0],
    input  pkt_check_pkg::keep_t      s_tkeep     [`PKT_NUM_PORTS-1:0],
    input  logic                      s_tvalid    [`PKT_NUM_PORTS-1:0],
    input  logic                      s_tlast     [`PKT_NUM_PORTS-1:0],
    input  pkt_check_pkg::dest_t      s_tdest     [`PKT_NUM_PORTS-1:0],
    input  logic                      tready_in   [`PKT_NUM_PORTS-1:0],
    output logic                      beat_fire   [`PKT_NUM_PORTS-1:0],
    input  logic                      load_we,
    input  logic                      load_desc_we,
    input  pkt_check_pkg::port_idx_t  load_port,
    input  pkt_check_pkg::pkt_idx_t   load_pkt,
    input  pkt_check_pkg::beat_idx_t  load_beat,
    input  pkt_check_pkg::beat_t      load_data,
    input  pkt_check_pkg::blen_t      load_blen,
    input  pkt_check_pkg::dest_t      load_dest,
    input  pkt_check_pkg::cnt_t       num_tx_pkts [`PKT_NUM_PORTS-1:0],
    output logic                      pkt_done    [`PKT_NUM_PORTS-1:0],
    output logic                      pkt_ok      [`PKT_NUM_PORTS-1:0],
    output logic                      all_done    [`PKT_NUM_PORTS-1:0],
    output pkt_check_pkg::cnt_t       pkt_count   [`PKT_NUM_PORTS-1:0],
    output pkt_check_pkg::cnt_t       err_count   [`PKT_NUM_PORTS-1:0]
);

    import pkt_check_pkg::*;

    pkt_desc_t load_desc;

    assign load_desc = '{blen: load_blen, dest: load_dest};

    for (genvar p = 0; p < `PKT_NUM_PORTS; p++) begin : g_port
        logic data_we;
        logic desc_we;

        // Only the addressed port sees a write.
        assign data_we = load_we & (load_port == port_idx_t'(p));
        assign desc_we = load_desc_we & (load_port == port_idx_t'(p));

        packet_checker u_packet_checker (
            .clk         ( clk            ),
            .rst_n       ( rst_n          ),
            .tdata       ( s_tdata[p]     ),
            .tkeep       ( s_tkeep[p]     ),
            .tvalid      ( s_tvalid[p]    ),
            .tlast       ( s_tlast[p]     ),
            .tdest       ( s_tdest[p]     ),
            .tready_in   ( tready_in[p]   ),
            .beat_fire   ( beat_fire[p]   ),
            .data_we     ( data_we        ),
            .desc_we     ( desc_we        ),
            .load_pkt    ( load_pkt       ),
            .load_beat   ( load_beat      ),
            .load_data   ( load_data      ),
            .load_desc   ( load_desc      ),
            .num_tx_pkts ( num_tx_pkts[p] ),
            .pkt_done    ( pkt_done[p]    ),
            .pkt_ok      ( pkt_ok[p]      ),
            .all_done    ( all_done[p]    ),
            .pkt_count   ( pkt_count[p]   ),
            .err_count   ( err_count[p]   )
        );
    end

endmodule

// File: project.f
+incdir+common
common/pkt_check_pkg.sv
packet_checker/expected_pkt_store.sv
source/ready_throttle.sv
packet_checker/packet_checker.sv
packet_checker/packet_checker_array.sv
source/pkt_check_top.sv
tests/pkt_check_properties.sv
tests/pkt_check_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the packet checker testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module pkt_check_tb \
    -f project.f \
    -o pkt_check_sim

./obj_dir/pkt_check_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
else
    exit 1
fi

// File: source/pkt_check_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multi-port stream packet checker with per-port ready throttles.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pkt_check_defines.svh"
`timescale 1ns/1ps

module pkt_check_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  pkt_check_pkg::beat_t      s_tdata     [`PKT_NUM_PORTS-1:0],
    input  pkt_check_pkg::keep_t      s_tkeep     [`PKT_NUM_PORTS-1:0],
    input  logic                      s_tvalid    [`PKT_NUM_PORTS-1:0],
    input  logic                      s_tlast     [`PKT_NUM_PORTS-1:0],
    input  pkt_check_pkg::dest_t      s_tdest     [`PKT_NUM_PORTS-1:0],
    output logic                      s_tready    [`PKT_NUM_PORTS-1:0],
    input  logic                      load_we,
    input  logic                      load_desc_we,
    input  pkt_check_pkg::port_idx_t  load_port,
    input  pkt_check_pkg::pkt_idx_t   load_pkt,
    input  pkt_check_pkg::beat_idx_t  load_beat,
    input  pkt_check_pkg::beat_t      load_data,
    input  pkt_check_pkg::blen_t      load_blen,
    input  pkt_check_pkg::dest_t      load_dest,
    input  pkt_check_pkg::cnt_t       num_tx_pkts [`PKT_NUM_PORTS-1:0],
    input  pkt_check_pkg::stall_t     max_stall,
    output logic                      pkt_done    [`PKT_NUM_PORTS-1:0],
    output logic                      pkt_ok      [`PKT_NUM_PORTS-1:0],
    output logic                      all_done    [`PKT_NUM_PORTS-1:0],
    output pkt_check_pkg::cnt_t       pkt_count   [`PKT_NUM_PORTS-1:0],
    output pkt_check_pkg::cnt_t       err_count   [`PKT_NUM_PORTS-1:0]
);

    logic beat_fire [`PKT_NUM_PORTS-1:0];        // Accepted beats, back to the throttles.

    packet_checker_array u_packet_checker_array (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .s_tdata      ( s_tdata      ),
        .s_tkeep      ( s_tkeep      ),
        .s_tvalid     ( s_tvalid     ),
        .s_tlast      ( s_tlast      ),
        .s_tdest      ( s_tdest      ),
        .tready_in    ( s_tready     ),
        .beat_fire    ( beat_fire    ),
        .load_we      ( load_we      ),
        .load_desc_we ( load_desc_we ),
        .load_port    ( load_port    ),
        .load_pkt     ( load_pkt     ),
        .load_beat    ( load_beat    ),
        .load_data    ( load_data    ),
        .load_blen    ( load_blen    ),
        .load_dest    ( load_dest    ),
        .num_tx_pkts  ( num_tx_pkts  ),
        .pkt_done     ( pkt_done     ),
        .pkt_ok       ( pkt_ok       ),
        .all_done     ( all_done     ),
        .pkt_count    ( pkt_count    ),
        .err_count    ( err_count    )
    );

    for (genvar p = 0; p < `PKT_NUM_PORTS; p++) begin : g_throttle
        ready_throttle u_ready_throttle (
            .clk       ( clk          ),
            .rst_n     ( rst_n        ),
            .max_stall ( max_stall    ),
            .beat_fire ( beat_fire[p] ),
            .ready     ( s_tready[p]  )
        );
    end

endmodule

// File: source/ready_throttle.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pseudo-random tready generator with bounded stalls.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ready_throttle (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pkt_check_pkg::stall_t max_stall,
    input  logic                  beat_fire,
    output logic                  ready
);

    import pkt_check_pkg::*;

    localparam logic [15:0] LFSR_SEED = 16'hace1;

    logic [15:0] lfsr;
    logic        lfsr_fb;
    stall_t      draw;
    stall_t      stall_cnt;

    // x^16 + x^14 + x^13 + x^11, maximal length.
    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    // Stall length folded into 0 .. max_stall.
    assign draw = stall_t'(lfsr[7:0] % ({4'd0, max_stall} + 8'd1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[14:0], lfsr_fb};       // Free-running.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready     <= 1'b0;
            stall_cnt <= '0;
        end else if (beat_fire) begin
            if (draw == '0) begin
                ready <= 1'b1;                   // No stall this time.
            end else begin
                ready     <= 1'b0;
                stall_cnt <= draw - 1'b1;        // Low for draw cycles.
            end
        end else if (!ready) begin
            if (stall_cnt == '0) begin
                ready <= 1'b1;
            end else begin
                stall_cnt <= stall_cnt - 1'b1;
            end
        end
    end

endmodule

// File: tests/pkt_check_properties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Handshake and status assertions, bound into every packet checker.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pkt_check_properties (
    input logic                 clk,
    input logic                 rst_n,
    input pkt_check_pkg::beat_t tdata,
    input pkt_check_pkg::keep_t tkeep,
    input logic                 tvalid,
    input logic                 tready_in,
    input logic                 tlast,
    input pkt_check_pkg::dest_t tdest,
    input logic                 beat_fire,
    input logic                 pkt_done,
    input logic                 pkt_ok,
    input logic                 all_done,
    input pkt_check_pkg::cnt_t  pkt_count,
    input pkt_check_pkg::cnt_t  err_count
);

    import pkt_check_pkg::*;

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        pkt_done |=> !pkt_done)
        else $error("pkt_done held longer than one cycle");

    // Counters move together with the result pulse.
    a_done_after_last: assert property (@(posedge clk) disable iff (!rst_n)
        (beat_fire && tlast) |=> (pkt_done && pkt_count == $past(pkt_count) + 1'b1
                                  && err_count == $past(err_count) + cnt_t'(!pkt_ok)))
        else $error("no pkt_done with counter update one cycle after a tlast transfer");

    // A stalled beat stays on the bus until it is taken.
    a_hold_until_fire: assert property (@(posedge clk) disable iff (!rst_n)
        (tvalid && !tready_in) |=> (tvalid && $stable(tdata) && $stable(tkeep)
                                    && $stable(tlast) && $stable(tdest)))
        else $error("stalled beat changed before it was accepted");

    // Status is cleared one edge into reset.
    a_reset_low: assert property (@(posedge clk)
        !rst_n |=> (!pkt_done && !pkt_ok && !all_done && pkt_count == '0 && err_count == '0))
        else $error("status outputs not cleared by reset");

endmodule

bind packet_checker pkt_check_properties u_pkt_check_properties (.*);

// File: tests/pkt_check_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the stream packet checker with reference model and report.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pkt_check_defines.svh"
`timescale 1ns/1ps

module pkt_check_tb;

    import pkt_check_pkg::*;

    localparam int NP         = `PKT_NUM_PORTS;
    localparam int NK         = `PKT_NUM_PKTS;
    localparam int MTU        = `PKT_MTU_BYTES;
    localparam int NUM_TESTS  = 5;
    localparam int BP_STALL   = 5;
    localparam int LOAD_CYCLES = NP * NK * (MTU / `PKT_DATA_BYTES + 1) + 2;
    localparam int BEATS_PORT = NUM_TESTS * NK * (MTU / `PKT_DATA_BYTES + 1);
    localparam int TIMEOUT_CYCLES = 16 + NUM_TESTS * LOAD_CYCLES
                                  + BEATS_PORT * (BP_STALL + 1) + 500;

    logic      clk;
    logic      rst_n;
    beat_t     s_tdata     [NP-1:0];
    keep_t     s_tkeep     [NP-1:0];
    logic      s_tvalid    [NP-1:0];
    logic      s_tlast     [NP-1:0];
    dest_t     s_tdest     [NP-1:0];
    logic      s_tready    [NP-1:0];
    logic      load_we;
    logic      load_desc_we;
    port_idx_t load_port;
    pkt_idx_t  load_pkt;
    beat_idx_t load_beat;
    beat_t     load_data;
    blen_t     load_blen;
    dest_t     load_dest;
    cnt_t      num_tx_pkts [NP-1:0];
    stall_t    max_stall;
    logic      pkt_done    [NP-1:0];
    logic      pkt_ok      [NP-1:0];
    logic      all_done    [NP-1:0];
    cnt_t      pkt_count   [NP-1:0];
    cnt_t      err_count   [NP-1:0];

    // Expected and transmitted packets, per port and store slot.
    logic [7:0] exp_bytes [NP][NK][MTU];
    logic [7:0] tx_bytes  [NP][NK][MTU];
    int         exp_len   [NP][NK];
    int         tx_len    [NP][NK];
    dest_t      exp_dest  [NP][NK];
    dest_t      tx_dest   [NP][NK];

    int    model_count [NP];             // Packets reported so far.
    int    model_err   [NP];
    int    ready_gap   [NP];
    int    n_checks;
    int    n_errors;
    int    cycles;
    bit    gap_en;
    string cur_test;

    pkt_check_top u_pkt_check_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic beat_t pack_beat(input bit from_tx, input int p, input int s,
                                        input int b);
        beat_t v;
        v = '0;
        for (int k = 0; k < `PKT_DATA_BYTES; k++) begin
            v[8*k +: 8] = from_tx ? tx_bytes[p][s][4*b+k] : exp_bytes[p][s][4*b+k];
        end
        return v;
    endfunction

    function automatic keep_t keep_of(input int len, input int b);
        int n;
        n = len - `PKT_DATA_BYTES * b;
        if (n >= `PKT_DATA_BYTES) return '1;
        return keep_t'((1 << n) - 1);
    endfunction

    // Pass rule: same length, same tdest, every kept byte as expected.
    function automatic bit pass_expected(input int p, input int s);
        if (tx_len[p][s] != exp_len[p][s]) return 1'b0;
        if (tx_dest[p][s] != exp_dest[p][s]) return 1'b0;
        for (int i = 0; i < tx_len[p][s]; i++) begin
            if (tx_bytes[p][s][i] != exp_bytes[p][s][i]) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic check_ok(input string what, input bit exp, input bit act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("mismatch %s %s: expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input cnt_t exp, input cnt_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("mismatch %s %s: expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_ready_gap(input int p, input int gap);
        n_checks++;
        if (gap > int'(max_stall)) begin
            n_errors++;
            $display("%s: port %0d held tready low for %0d cycles, more than %0d allowed",
                     cur_test, p, gap, max_stall);
        end
    endtask

    // Reference result of one reported packet.
    task automatic compare_port(input int p);
        bit exp_ok;
        if (pkt_done[p]) begin
            exp_ok = pass_expected(p, model_count[p] % NK);
            model_count[p]++;
            if (!exp_ok) model_err[p]++;
            check_ok($sformatf("port %0d pkt_ok", p), exp_ok, pkt_ok[p]);
            check_count($sformatf("port %0d pkt_count", p), cnt_t'(model_count[p]),
                        pkt_count[p]);
            check_count($sformatf("port %0d err_count", p), cnt_t'(model_err[p]),
                        err_count[p]);
        end
        check_ok($sformatf("port %0d all_done", p),
                 (num_tx_pkts[p] != 0) && (model_count[p] >= int'(num_tx_pkts[p])),
                 all_done[p]);
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < NP; p++) begin
                compare_port(p);
                ready_gap[p] = s_tready[p] ? 0 : ready_gap[p] + 1;
                if (gap_en && ready_gap[p] != 0) check_ready_gap(p, ready_gap[p]);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: run went past %0d cycles in %s", TIMEOUT_CYCLES, cur_test);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic build_packets(input int kind);
        for (int p = 0; p < NP; p++) begin
            for (int s = 0; s < NK; s++) begin
                exp_len[p][s]  = 5 + $urandom % 56;                // No single-beat packets.
                exp_dest[p][s] = dest_t'($urandom);
                for (int i = 0; i < MTU; i++) exp_bytes[p][s][i] = 8'($urandom);
                if (kind inside {0, 1, 2} && s == 1) begin
                    exp_len[p][s] = 4 * (1 + $urandom % 12) + 3;   // Partial last beat.
                end
                tx_bytes[p][s] = exp_bytes[p][s];
                tx_len[p][s]   = exp_len[p][s];
                tx_dest[p][s]  = exp_dest[p][s];
            end
            if (kind == 1) begin
                tx_bytes[p][0][$urandom % exp_len[p][0]] ^= 8'hff;
                tx_bytes[p][1][exp_len[p][1]] ^= 8'hff;          // Byte under tkeep low.
            end else if (kind == 2) begin
                tx_len[p][0]  = exp_len[p][0] + 4;
                tx_len[p][1]  = exp_len[p][1] - 1;
                tx_dest[p][2] = exp_dest[p][2] + 1'b1;
            end
        end
    endtask

    task automatic load_expectations();
        for (int p = 0; p < NP; p++) begin
            for (int s = 0; s < NK; s++) begin
                for (int b = 0; b < (exp_len[p][s] + 3) / 4; b++) begin
                    @(posedge clk);
                    #1;
                    load_we      = 1'b1;
                    load_desc_we = 1'b0;
                    load_port    = port_idx_t'(p);
                    load_pkt     = pkt_idx_t'(s);
                    load_beat    = beat_idx_t'(b);
                    load_data    = pack_beat(1'b0, p, s, b);
                end
                @(posedge clk);
                #1;
                load_we      = 1'b0;
                load_desc_we = 1'b1;
                load_blen    = blen_t'(exp_len[p][s]);
                load_dest    = exp_dest[p][s];
            end
        end
        @(posedge clk);
        #1;
        load_we      = 1'b0;
        load_desc_we = 1'b0;
    endtask

    task automatic send_port(input int p);
        int nb;
        for (int s = 0; s < NK; s++) begin
            nb = (tx_len[p][s] + 3) / 4;
            for (int b = 0; b < nb; b++) begin
                @(posedge clk);
                #1;
                s_tvalid[p] = 1'b1;
                s_tdata[p]  = pack_beat(1'b1, p, s, b);
                s_tkeep[p]  = keep_of(tx_len[p][s], b);
                s_tlast[p]  = (b == nb - 1);
                s_tdest[p]  = tx_dest[p][s];
                // Held until tready is seen high ahead of an edge.
                do @(negedge clk); while (!s_tready[p]);
            end
        end
        @(posedge clk);
        #1;
        s_tvalid[p] = 1'b0;
        s_tlast[p]  = 1'b0;
    endtask

    task automatic run_test(input string name, input int kind, input int stall,
                            input bit set_target);
        int err_before;
        int target [NP];
        cur_test   = name;
        err_before = n_errors;
        build_packets(kind);
        load_expectations();
        max_stall = stall_t'(stall);
        for (int p = 0; p < NP; p++) begin
            target[p] = model_count[p] + NK;
            if (set_target) num_tx_pkts[p] = cnt_t'(target[p]);
        end
        fork
            send_port(0);
            send_port(1);
        join
        while (model_count[0] != target[0] || model_count[1] != target[1]) begin
            @(negedge clk);
        end
        @(negedge clk);
        if (set_target) begin
            for (int p = 0; p < NP; p++) begin
                check_ok($sformatf("port %0d all_done at end", p), 1'b1, all_done[p]);
                check_count($sformatf("port %0d final pkt_count", p), cnt_t'(target[p]),
                            pkt_count[p]);
            end
        end
        $display("test %s finished with %0d errors", name, n_errors - err_before);
    endtask

    initial begin
        void'($urandom(49602));
        cur_test     = "reset";
        rst_n        = 1'b0;
        load_we      = 1'b0;
        load_desc_we = 1'b0;
        load_port    = '0;
        load_pkt     = '0;
        load_beat    = '0;
        load_data    = '0;
        load_blen    = '0;
        load_dest    = '0;
        max_stall    = '0;
        for (int p = 0; p < NP; p++) begin
            s_tdata[p]     = '0;
            s_tkeep[p]     = '0;
            s_tvalid[p]    = 1'b0;
            s_tlast[p]     = 1'b0;
            s_tdest[p]     = '0;
            num_tx_pkts[p] = '0;
            model_count[p] = 0;
            model_err[p]   = 0;
            ready_gap[p]   = 0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        for (int p = 0; p < NP; p++) begin
            check_count($sformatf("port %0d pkt_count after reset", p), '0, pkt_count[p]);
            check_count($sformatf("port %0d err_count after reset", p), '0, err_count[p]);
        end
        repeat (2) @(negedge clk);
        gap_en = 1'b1;                           // Ready is up by now.
        run_test("matching_packets", 0, 0, 1'b0);
        run_test("corrupted_data", 1, 0, 1'b0);
        run_test("length_and_dest", 2, 0, 1'b0);
        run_test("back_pressure", 3, BP_STALL, 1'b0);
        run_test("completion", 4, BP_STALL, 1'b1);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
